//--- tb.f
src/qla_pkg.sv
src/reg_write_decode.sv
src/cur_cmd_bank.sv
src/safety_check.sv
src/reg_read_mux.sv
src/qla_channel_regs.sv
verification/tb_qla_channel_regs.sv

//--- Makefile
# Verilator build and run of the motor channel register testbench
VERILATOR ?= verilator
TOP       ?= tb_qla_channel_regs
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, fail unless it passes"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

//--- verification/tb_qla_channel_regs.sv
// testbench for qla_channel_regs; model follows the registered clear (write edge plus 1), fixed lfsr seed
module tb_qla_channel_regs;
    timeunit 1ns;
    timeprecision 1ps;
    import qla_pkg::*;

    localparam int     RST_CYCLES   = 10;
    localparam int     SWEEP_LEN    = 128;      // 2 spaces x 16 channels x 4 offsets
    localparam int     N_RAND_WR    = 150;
    localparam int     N_BLK_SINGLE = 4;
    localparam int     N_BLK_ROUNDS = 8;
    localparam int     TIMEOUT_CYCLES = RST_CYCLES + SWEEP_LEN + 2 * N_RAND_WR +
                                        3 * N_BLK_SINGLE + 32 * N_BLK_ROUNDS +
                                        14 * NUM_CHANNELS + 20 + 100;   // plus margin
    localparam addr_t  IDLE_ADDR   = 16'hf0f0;   // space f, decodes to nothing
    localparam addr_t  STATUS_ADDR = 16'h0000;
    localparam logic [31:0] LFSR_TAPS = 32'hb4bcd35c;

    logic  sysclk;
    logic  rst_n;
    logic  reg_wen;
    logic  blk_wen;
    addr_t reg_waddr;
    data_t reg_wdata;
    addr_t reg_raddr;
    data_t reg_rdata;
    cur_t  cur_fb_1, cur_fb_2, cur_fb_3, cur_fb_4;
    logic  cur_fb_wen;
    logic  dac_busy;
    cur_t  cur_cmd_1, cur_cmd_2, cur_cmd_3, cur_cmd_4;
    logic  dac_load;
    logic [3:0] amp_disable;

    // ----------------------------------------
    // reference model state
    // ----------------------------------------
    cur_t        m_cmd [NUM_CHANNELS];
    logic        m_load_req;
    logic        m_dac_load;
    int          m_cnt [NUM_CHANNELS];   // bad samples in a row
    logic [3:0]  m_dis;
    logic [3:0]  m_clr;                  // clear pending for next edge
    logic [31:0] lfsr;
    int          val_errors, other_errors, load_pulses, cycles;

    qla_channel_regs dut0 (.*);

    always #10 sysclk = ~sysclk;   // 20 ns period

    // ----------------------------------------
    // random source and reference functions
    // ----------------------------------------
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};   // one step per bit
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ LFSR_TAPS) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic cur_t signed_code(input cur_t mag);
        return (rand_bits(1) != 0) ? CUR_MID + mag : CUR_MID - mag;   // random polarity
    endfunction

    function automatic cur_t bad_code();
        return signed_code(16'd769 + cur_t'(rand_bits(14)));   // beyond 2*255 + 256
    endfunction

    function automatic addr_t rand_dac_addr();
        return {ADDR_MAIN, 4'h0, chan_t'(1 + rand_bits(2)), OFF_DAC_CTRL};
    endfunction

    function automatic logic over_limit(input cur_t fb, input cur_t cmd);
        int fb_m;
        int cmd_m;
        fb_m  = (fb >= CUR_MID) ? int'(fb) - int'(CUR_MID) : int'(CUR_MID) - int'(fb);
        cmd_m = (cmd >= CUR_MID) ? int'(cmd) - int'(CUR_MID) : int'(CUR_MID) - int'(cmd);
        return fb_m > 2 * cmd_m + int'(SAFETY_MARGIN);
    endfunction

    function automatic cur_t fb_input(input int k);
        case (k)
            0:       return cur_fb_1;
            1:       return cur_fb_2;
            2:       return cur_fb_3;
            default: return cur_fb_4;
        endcase
    endfunction

    function automatic data_t expected_rdata(input addr_t a);
        int k;
        if (a[15:12] != ADDR_MAIN) return '0;
        if (a[7:4] == 4'd0) return (a[3:0] == OFF_STATUS) ? {28'd0, m_dis} : '0;
        if (int'(a[7:4]) > NUM_CHANNELS) return '0;
        k = int'(a[7:4]) - 1;
        if (a[3:0] == OFF_ADC_DATA) return {16'd0, fb_input(k)};
        if (a[3:0] == OFF_DAC_CTRL) return {16'd0, m_cmd[k]};
        return '0;
    endfunction

    // ----------------------------------------
    // compare tasks
    // ----------------------------------------
    task automatic check_cur(input string name, input cur_t got, input cur_t exp);
        if (got !== exp) begin
            val_errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            val_errors++;
            $display("error at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            val_errors++;
            $display("error at %0t ns: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // compare outputs of the last cycle, then step the model with this edge's inputs
    always @(posedge sysclk) begin : compare_and_step
        cur_t  got_cmd [NUM_CHANNELS];
        logic  hit;
        logic  status_hit;
        got_cmd[0] = cur_cmd_1;
        got_cmd[1] = cur_cmd_2;
        got_cmd[2] = cur_cmd_3;
        got_cmd[3] = cur_cmd_4;
        if (!rst_n) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                m_cmd[i] = CUR_MID;
                m_cnt[i] = 0;
            end
            m_load_req = 1'b0;
            m_dac_load = 1'b0;
            m_dis      = '0;
            m_clr      = '0;
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                check_cur($sformatf("cur_cmd_%0d", i + 1), got_cmd[i], m_cmd[i]);
                check_bit($sformatf("amp_disable[%0d]", i), amp_disable[i], m_dis[i]);
            end
            check_bit("dac_load", dac_load, m_dac_load);
            check_data("reg_rdata", reg_rdata, expected_rdata(reg_raddr));
            if (dac_load) load_pulses++;
            hit = (reg_waddr[15:12] == ADDR_MAIN) && (reg_waddr[3:0] == OFF_DAC_CTRL) &&
                  (reg_waddr[7:4] != 4'd0) && (int'(reg_waddr[7:4]) <= NUM_CHANNELS);
            status_hit = reg_wen && (reg_waddr[15:12] == ADDR_MAIN) &&
                         (reg_waddr[7:4] == 4'd0) && (reg_waddr[3:0] == OFF_STATUS);
            m_dac_load = m_load_req && !dac_busy;   // pending request meets idle dac
            if (hit) m_load_req = blk_wen;
            else if (m_dac_load) m_load_req = 1'b0;
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (m_clr[i]) begin
                    m_cnt[i] = 0;   // clear wins over a bad sample
                    m_dis[i] = 1'b0;
                end else if (cur_fb_wen) begin
                    if (over_limit(fb_input(i), m_cmd[i])) begin
                        m_cnt[i]++;
                        if (m_cnt[i] >= SAFETY_LIMIT) m_dis[i] = 1'b1;
                    end else begin
                        m_cnt[i] = 0;
                    end
                end
                m_clr[i] = status_hit && (reg_wdata[PWR_EN_BIT] || reg_wdata[AMP_EN_LSB + i]);
            end
            if (reg_wen && hit) m_cmd[int'(reg_waddr[7:4]) - 1] = reg_wdata[15:0];
        end
    end

    always @(posedge sysclk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    // ----------------------------------------
    // stimulus tasks, all on the falling edge
    // ----------------------------------------
    task automatic write_reg(input addr_t a, input data_t d, input logic blk);
        @(negedge sysclk);
        reg_wen   = 1'b1;
        blk_wen   = blk;
        reg_waddr = a;
        reg_wdata = d;
        @(negedge sysclk);
        reg_wen   = 1'b0;
        blk_wen   = 1'b0;
        reg_waddr = IDLE_ADDR;   // park so the request is not overwritten
        reg_raddr = a;           // readback one edge after the write
    endtask

    task automatic sample_axis(input int axis, input cur_t fb);
        @(negedge sysclk);
        cur_fb_1   = (axis == 0) ? fb : CUR_MID;   // other axes sit at zero current
        cur_fb_2   = (axis == 1) ? fb : CUR_MID;
        cur_fb_3   = (axis == 2) ? fb : CUR_MID;
        cur_fb_4   = (axis == 3) ? fb : CUR_MID;
        cur_fb_wen = 1'b1;
        @(negedge sysclk);
        cur_fb_wen = 1'b0;
    endtask

    task automatic wait_dac_load(input int max_cycles);
        logic seen;
        seen = 1'b0;
        for (int c = 0; c < max_cycles && !seen; c++) begin
            @(negedge sysclk);
            seen = dac_load;
        end
        if (!seen) begin
            other_errors++;
            $display("dac_load never pulsed within %0d cycles after the dac went idle", max_cycles);
        end
    endtask

    initial begin
        int nwr;
        int hold;
        int p0;
        lfsr = 32'h3ce9;
        sysclk = 1'b0;
        rst_n = 1'b0;
        {reg_wen, blk_wen, cur_fb_wen, dac_busy} = '0;
        reg_waddr = IDLE_ADDR;
        reg_wdata = '0;
        reg_raddr = '0;
        {cur_fb_1, cur_fb_2, cur_fb_3, cur_fb_4} = {4{CUR_MID}};
        {val_errors, other_errors, load_pulses, cycles} = '0;
        repeat (RST_CYCLES) @(posedge sysclk);
        @(negedge sysclk);
        rst_n = 1'b1;

        // 1: reset values and address sweep
        for (int a = 0; a < SWEEP_LEN; a++) begin
            @(negedge sysclk);
            reg_raddr = {4'(a / 64), 4'h0, 4'(a / 4), 4'(a % 4)};
        end

        // 2: random writes across spaces, channels, offsets
        for (int w = 0; w < N_RAND_WR; w++) begin
            write_reg({(rand_bits(1) != 0) ? ADDR_MAIN : 4'(rand_bits(4)), 4'(rand_bits(4)),
                       4'(rand_bits(4)), (rand_bits(1) != 0) ? OFF_DAC_CTRL : 4'(rand_bits(4))},
                      rand_bits(32), 1'b0);
        end

        // 3: block writes, idle dac then busy dac
        for (int b = 0; b < N_BLK_SINGLE; b++) begin
            write_reg(rand_dac_addr(), rand_bits(32), 1'b1);
            @(negedge sysclk);
            check_bit("dac_load at write edge plus 1", dac_load, 1'b1);
        end
        for (int r = 0; r < N_BLK_ROUNDS; r++) begin
            @(negedge sysclk);
            dac_busy = 1'b1;
            p0 = load_pulses;   // earlier pulse already counted by now
            nwr = 1 + int'(rand_bits(2));
            for (int w = 0; w < nwr; w++) write_reg(rand_dac_addr(), rand_bits(32), 1'b1);
            hold = 1 + int'(rand_bits(4));
            repeat (hold) @(negedge sysclk);
            dac_busy = 1'b0;
            wait_dac_load(4);
            repeat (3) @(negedge sysclk);
            if (load_pulses - p0 != 1) begin
                other_errors++;
                $display("expected one dac_load pulse after busy release, saw %0d",
                         load_pulses - p0);
            end
        end

        // 4: over-current runs, one axis at a time
        for (int ax = 0; ax < NUM_CHANNELS; ax++) begin
            write_reg({ADDR_MAIN, 4'h0, chan_t'(ax + 1), OFF_DAC_CTRL},
                      {16'd0, signed_code(cur_t'(rand_bits(8)))}, 1'b0);
            reg_raddr = STATUS_ADDR;
            sample_axis(ax, bad_code());
            sample_axis(ax, bad_code());
            sample_axis(ax, signed_code(cur_t'(rand_bits(8))));   // breaks the run
            sample_axis(ax, bad_code());
            sample_axis(ax, bad_code());
            check_bit("amp_disable after broken run", amp_disable[ax], 1'b0);
            sample_axis(ax, bad_code());
            for (int j = 0; j < NUM_CHANNELS; j++) begin
                check_bit($sformatf("amp_disable[%0d] after run", j), amp_disable[j], j <= ax);
            end
        end

        // 5: clears by enable bits, then by power enable, then adc readback
        write_reg(STATUS_ADDR, data_t'(1) << AMP_EN_LSB, 1'b0);
        write_reg(STATUS_ADDR, data_t'(1) << (AMP_EN_LSB + 2), 1'b0);
        @(negedge sysclk);   // clear lands one edge later
        check_data("status after axis clears", reg_rdata, 32'h0000_000a);
        write_reg(STATUS_ADDR, data_t'(1) << PWR_EN_BIT, 1'b0);
        @(negedge sysclk);
        check_data("status after power enable", reg_rdata, 32'h0);
        for (int k = 0; k < 8; k++) begin
            @(negedge sysclk);
            cur_fb_1  = cur_t'(rand_bits(16));
            cur_fb_2  = cur_t'(rand_bits(16));
            cur_fb_3  = cur_t'(rand_bits(16));
            cur_fb_4  = cur_t'(rand_bits(16));
            reg_raddr = {ADDR_MAIN, 4'h0, chan_t'(1 + rand_bits(2)), OFF_ADC_DATA};
        end
        repeat (3) @(negedge sysclk);

        if (load_pulses == 0) begin
            other_errors++;
            $display("no dac_load pulse was seen during the run");
        end
        $display("errors: %0d value mismatches, %0d other failures", val_errors, other_errors);
        if (val_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- src/qla_channel_regs.sv
// motor channel register block, top level; one write bus master, single sysclk domain
module qla_channel_regs (
    input  logic           sysclk,
    input  logic           rst_n,
    // write bus
    input  logic           reg_wen,
    input  logic           blk_wen,
    input  qla_pkg::addr_t reg_waddr,
    input  qla_pkg::data_t reg_wdata,
    // read port
    input  qla_pkg::addr_t reg_raddr,
    output qla_pkg::data_t reg_rdata,
    // adc feedback
    input  qla_pkg::cur_t  cur_fb_1,
    input  qla_pkg::cur_t  cur_fb_2,
    input  qla_pkg::cur_t  cur_fb_3,
    input  qla_pkg::cur_t  cur_fb_4,
    input  logic           cur_fb_wen,
    // dac side
    input  logic           dac_busy,
    output qla_pkg::cur_t  cur_cmd_1,
    output qla_pkg::cur_t  cur_cmd_2,
    output qla_pkg::cur_t  cur_cmd_3,
    output qla_pkg::cur_t  cur_cmd_4,
    output logic           dac_load,
    // amplifier interlock
    output logic [3:0]     amp_disable   // bit 0 is axis 1
);

    logic           cmd_wen;
    logic           cmd_req;
    logic           cmd_space;
    qla_pkg::chan_t cmd_chan;
    qla_pkg::cur_t  cmd_data;
    logic [3:0]     clear_disable;

    // ----------------------------------------
    // decode and command bank
    // ----------------------------------------
    reg_write_decode wdec (
        .sysclk(sysclk), .rst_n(rst_n),
        .reg_wen(reg_wen), .blk_wen(blk_wen), .reg_waddr(reg_waddr), .reg_wdata(reg_wdata),
        .cmd_wen(cmd_wen), .cmd_req(cmd_req), .cmd_space(cmd_space),
        .cmd_chan(cmd_chan), .cmd_data(cmd_data), .clear_disable(clear_disable)
    );

    cur_cmd_bank bank (
        .sysclk(sysclk), .rst_n(rst_n),
        .cmd_wen(cmd_wen), .cmd_req(cmd_req), .cmd_space(cmd_space),
        .cmd_chan(cmd_chan), .cmd_data(cmd_data), .dac_busy(dac_busy),
        .cur_cmd_1(cur_cmd_1), .cur_cmd_2(cur_cmd_2),
        .cur_cmd_3(cur_cmd_3), .cur_cmd_4(cur_cmd_4),
        .dac_load(dac_load)
    );

    // ----------------------------------------
    // per-axis safety, axis k on bit k-1
    // ----------------------------------------
    safety_check safe1 (.sysclk(sysclk), .rst_n(rst_n), .cur_fb(cur_fb_1), .cur_cmd(cur_cmd_1),
        .cur_fb_wen(cur_fb_wen), .clear_disable(clear_disable[0]), .amp_disable(amp_disable[0]));

    safety_check safe2 (.sysclk(sysclk), .rst_n(rst_n), .cur_fb(cur_fb_2), .cur_cmd(cur_cmd_2),
        .cur_fb_wen(cur_fb_wen), .clear_disable(clear_disable[1]), .amp_disable(amp_disable[1]));

    safety_check safe3 (.sysclk(sysclk), .rst_n(rst_n), .cur_fb(cur_fb_3), .cur_cmd(cur_cmd_3),
        .cur_fb_wen(cur_fb_wen), .clear_disable(clear_disable[2]), .amp_disable(amp_disable[2]));

    safety_check safe4 (.sysclk(sysclk), .rst_n(rst_n), .cur_fb(cur_fb_4), .cur_cmd(cur_cmd_4),
        .cur_fb_wen(cur_fb_wen), .clear_disable(clear_disable[3]), .amp_disable(amp_disable[3]));

    // ----------------------------------------
    // readback
    // ----------------------------------------
    reg_read_mux rmux (
        .reg_raddr(reg_raddr),
        .cur_fb_1(cur_fb_1), .cur_fb_2(cur_fb_2), .cur_fb_3(cur_fb_3), .cur_fb_4(cur_fb_4),
        .cur_cmd_1(cur_cmd_1), .cur_cmd_2(cur_cmd_2),
        .cur_cmd_3(cur_cmd_3), .cur_cmd_4(cur_cmd_4),
        .amp_disable(amp_disable),
        .reg_rdata(reg_rdata)
    );

endmodule

//--- src/reg_read_mux.sv
// combinational read data for the main space; everything outside channels 0 to 4 reads as zero
module reg_read_mux (
    input  qla_pkg::addr_t reg_raddr,
    input  qla_pkg::cur_t  cur_fb_1,
    input  qla_pkg::cur_t  cur_fb_2,
    input  qla_pkg::cur_t  cur_fb_3,
    input  qla_pkg::cur_t  cur_fb_4,
    input  qla_pkg::cur_t  cur_cmd_1,
    input  qla_pkg::cur_t  cur_cmd_2,
    input  qla_pkg::cur_t  cur_cmd_3,
    input  qla_pkg::cur_t  cur_cmd_4,
    input  logic [3:0]     amp_disable,   // bit 0 is axis 1
    output qla_pkg::data_t reg_rdata
);
    import qla_pkg::*;

    logic [3:0] rd_space;
    chan_t      rd_chan;
    logic [3:0] rd_off;
    cur_t       fb_sel;    // feedback of the addressed axis
    cur_t       cmd_sel;   // command of the addressed axis

    assign rd_space = reg_raddr[SPACE_LSB +: 4];
    assign rd_chan  = reg_raddr[CHAN_LSB +: 4];
    assign rd_off   = reg_raddr[OFF_LSB +: 4];

    // ----------------------------------------
    // per-axis select
    // ----------------------------------------
    always_comb begin
        case (rd_chan)
            4'd1:    begin fb_sel = cur_fb_1; cmd_sel = cur_cmd_1; end
            4'd2:    begin fb_sel = cur_fb_2; cmd_sel = cur_cmd_2; end
            4'd3:    begin fb_sel = cur_fb_3; cmd_sel = cur_cmd_3; end
            4'd4:    begin fb_sel = cur_fb_4; cmd_sel = cur_cmd_4; end
            default: begin fb_sel = '0;       cmd_sel = '0;        end
        endcase
    end

    // ----------------------------------------
    // offset decode
    // ----------------------------------------
    always_comb begin
        reg_rdata = '0;
        if (rd_space == ADDR_MAIN) begin
            if (rd_chan == 4'd0) begin
                if (rd_off == OFF_STATUS) begin
                    reg_rdata = {28'd0, amp_disable};   // status, disables in low bits
                end
            end else if (rd_chan <= chan_t'(NUM_CHANNELS)) begin
                case (rd_off)
                    OFF_ADC_DATA: reg_rdata = {16'd0, fb_sel};    // current in low half
                    OFF_DAC_CTRL: reg_rdata = {16'd0, cmd_sel};
                    default:      reg_rdata = '0;
                endcase
            end
        end
    end

endmodule

//--- src/safety_check.sv
// over-current interlock for one axis; feedback and command share the offset-binary scale
module safety_check (
    input  logic          sysclk,
    input  logic          rst_n,
    input  qla_pkg::cur_t cur_fb,          // adc feedback sample
    input  qla_pkg::cur_t cur_cmd,         // commanded current
    input  logic          cur_fb_wen,      // new sample strobe
    input  logic          clear_disable,   // from a status write
    output logic          amp_disable      // latched until cleared
);
    import qla_pkg::*;

    cur_t        fb_mag;    // |feedback|, at most 16'h8000
    cur_t        cmd_mag;   // |command|
    logic [17:0] fb_limit;  // 2*cmd + margin, needs two extra bits
    logic        over;
    logic [$clog2(SAFETY_LIMIT + 1)-1:0] run_cnt;   // bad samples in a row

    // ----------------------------------------
    // magnitudes around midscale
    // ----------------------------------------
    always_comb begin
        if (cur_fb >= CUR_MID) begin
            fb_mag = cur_fb - CUR_MID;
        end else begin
            fb_mag = CUR_MID - cur_fb;
        end
    end

    always_comb begin
        if (cur_cmd >= CUR_MID) begin
            cmd_mag = cur_cmd - CUR_MID;
        end else begin
            cmd_mag = CUR_MID - cur_cmd;
        end
    end

    assign fb_limit = {1'b0, cmd_mag, 1'b0} + {2'b00, SAFETY_MARGIN};
    assign over     = {2'b00, fb_mag} > fb_limit;   // strictly beyond the limit

    // ----------------------------------------
    // run counter and disable latch
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            run_cnt     <= '0;
            amp_disable <= 1'b0;
        end else if (clear_disable) begin
            // clear beats a bad sample on the same edge
            run_cnt     <= '0;
            amp_disable <= 1'b0;
        end else if (cur_fb_wen) begin
            if (over) begin
                if (int'(run_cnt) < SAFETY_LIMIT) begin
                    run_cnt <= run_cnt + 1'b1;   // saturate at the limit
                end
                if (int'(run_cnt) >= SAFETY_LIMIT - 1) begin
                    amp_disable <= 1'b1;         // this sample completes the run
                end
            end else begin
                run_cnt <= '0;   // good sample breaks the run, disable stays
            end
        end
    end

endmodule

//--- src/cur_cmd_bank.sv
// commanded current bank with dac load request; load only follows block writes, never a single quadlet
module cur_cmd_bank (
    input  logic           sysclk,
    input  logic           rst_n,
    input  logic           cmd_wen,
    input  logic           cmd_req,
    input  logic           cmd_space,
    input  qla_pkg::chan_t cmd_chan,
    input  qla_pkg::cur_t  cmd_data,
    input  logic           dac_busy,      // level from the dac controller
    output qla_pkg::cur_t  cur_cmd_1,
    output qla_pkg::cur_t  cur_cmd_2,
    output qla_pkg::cur_t  cur_cmd_3,
    output qla_pkg::cur_t  cur_cmd_4,
    output logic           dac_load       // one-cycle pulse
);
    import qla_pkg::*;

    cur_t cmd_q [NUM_CHANNELS];   // index 0 is axis 1
    logic load_req;               // pending dac update
    logic load_go;

    // ----------------------------------------
    // command storage
    // ----------------------------------------
    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                cmd_q[i] <= CUR_MID;   // zero current out of reset
            end
        end else begin
            for (int i = 0; i < NUM_CHANNELS; i++) begin
                if (cmd_wen && (cmd_chan == chan_t'(i + 1))) begin
                    cmd_q[i] <= cmd_data;
                end
            end
        end
    end

    assign cur_cmd_1 = cmd_q[0];
    assign cur_cmd_2 = cmd_q[1];
    assign cur_cmd_3 = cmd_q[2];
    assign cur_cmd_4 = cmd_q[3];

    // ----------------------------------------
    // dac load request
    // ----------------------------------------
    assign load_go = load_req & ~dac_busy;   // wait out a busy dac

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            load_req <= 1'b0;
        end else if (cmd_space) begin
            load_req <= cmd_req;   // new access wins, even on a load edge
        end else if (load_go) begin
            load_req <= 1'b0;
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            dac_load <= 1'b0;
        end else begin
            dac_load <= load_go;   // pulses merge while busy
        end
    end

endmodule

//--- src/reg_write_decode.sv
// write bus decode for the main space; single bus master, status clears reach the axes one cycle late
module reg_write_decode (
    input  logic           sysclk,
    input  logic           rst_n,
    input  logic           reg_wen,        // one-cycle write strobe
    input  logic           blk_wen,        // level, block write in progress
    input  qla_pkg::addr_t reg_waddr,
    input  qla_pkg::data_t reg_wdata,
    output logic           cmd_wen,        // write one commanded current
    output logic           cmd_req,        // block flag for the load request
    output logic           cmd_space,      // any access at a valid dac address
    output qla_pkg::chan_t cmd_chan,
    output qla_pkg::cur_t  cmd_data,
    output logic [3:0]     clear_disable   // bit 0 is axis 1
);
    import qla_pkg::*;

    logic [3:0] wr_space;
    chan_t      wr_chan;
    logic [3:0] wr_off;
    logic       chan_valid;
    logic       status_wr;
    logic [3:0] clear_next;

    // ----------------------------------------
    // address fields
    // ----------------------------------------
    assign wr_space = reg_waddr[SPACE_LSB +: 4];
    assign wr_chan  = reg_waddr[CHAN_LSB +: 4];
    assign wr_off   = reg_waddr[OFF_LSB +: 4];

    // channel 0 is the board itself, and there are only four axes
    assign chan_valid = (wr_chan != 4'd0) && (wr_chan <= chan_t'(NUM_CHANNELS));

    assign cmd_space = (wr_space == ADDR_MAIN) && chan_valid && (wr_off == OFF_DAC_CTRL);
    assign cmd_wen   = cmd_space & reg_wen;   // data only moves on the strobe
    assign cmd_req   = blk_wen;
    assign cmd_chan  = wr_chan;
    assign cmd_data  = reg_wdata[15:0];       // low half holds the code

    // ----------------------------------------
    // status write, per-axis clears
    // ----------------------------------------
    assign status_wr = reg_wen && (wr_space == ADDR_MAIN) && (wr_chan == 4'd0) &&
                       (wr_off == OFF_STATUS);

    always_comb begin
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            // global power enable hits every axis
            clear_next[i] = reg_wdata[PWR_EN_BIT] | reg_wdata[AMP_EN_LSB + i];
        end
    end

    always_ff @(posedge sysclk) begin
        if (!rst_n) begin
            clear_disable <= '0;
        end else begin
            clear_disable <= status_wr ? clear_next : 4'd0;   // one-cycle pulse
        end
    end

endmodule

//--- src/qla_pkg.sv
// shared constants for the motor channel registers; four axes fixed, offset-binary current codes only
package qla_pkg;

    // ----------------------------------------
    // board geometry
    // ----------------------------------------
    localparam int NUM_CHANNELS = 4;          // motor axes on the board

    // address field positions in reg_waddr / reg_raddr
    localparam int SPACE_LSB = 12;            // bits 15..12 select the space
    localparam int CHAN_LSB  = 4;             // bits 7..4 select the channel
    localparam int OFF_LSB   = 0;             // bits 3..0 select the offset

    // ----------------------------------------
    // address spaces and offsets
    // ----------------------------------------
    localparam logic [3:0] ADDR_MAIN    = 4'h0;   // main board registers

    localparam logic [3:0] OFF_STATUS   = 4'h0;   // channel 0 only
    localparam logic [3:0] OFF_ADC_DATA = 4'h0;   // per axis, feedback
    localparam logic [3:0] OFF_DAC_CTRL = 4'h1;   // per axis, commanded current

    // status write bits
    localparam int PWR_EN_BIT = 19;           // clears every axis
    localparam int AMP_EN_LSB = 8;            // bits 8..11, one per axis

    // ----------------------------------------
    // current safety
    // ----------------------------------------
    localparam logic [15:0] CUR_MID       = 16'h8000;  // zero current in offset binary
    localparam logic [15:0] SAFETY_MARGIN = 16'd256;   // slack over twice the command
    localparam int          SAFETY_LIMIT  = 3;         // bad samples in a row before disable

    // ----------------------------------------
    // common word types
    // ----------------------------------------
    typedef logic [15:0] cur_t;               // current code
    typedef logic [15:0] addr_t;              // register address
    typedef logic [31:0] data_t;              // register data
    typedef logic [3:0]  chan_t;              // channel number

endpackage
